// File: vlog.f
source/bus_pkg.sv
source/cache_pkg.sv
source/line_store.sv
source/age_tracker.sv
source/access_port.sv
source/miss_controller.sv
source/unordered_cache.sv
test/backing_memory.sv
test/cache_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module cache_tb -f vlog.f

run: compile
	./obj_dir/Vcache_tb | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/cache_tb.sv
`timescale 1ns/1ns

module cache_tb;

	localparam int line_count = 4;
	localparam int age_width  = 4;
	localparam int wait_limit = 100;

	logic              clk = 1'b0;
	logic              reset;
	bus_pkg::cpu_req_t cpu_req;
	bus_pkg::cpu_rsp_t cpu_rsp;
	logic              ready;
	bus_pkg::mem_req_t mem_req;
	bus_pkg::mem_rsp_t mem_rsp;

	bus_pkg::data_t       ref_mem [256]; // what the client should see at every address
	logic                 line_valid [line_count];
	bus_pkg::addr_t       line_addr [line_count];
	bus_pkg::data_t       line_data [line_count];
	logic [age_width-1:0] line_age [line_count];

	// expectations for the request in flight
	logic           exp_hit;
	logic           exp_full;
	bus_pkg::addr_t exp_addr;
	bus_pkg::data_t exp_data;
	bus_pkg::addr_t exp_victim_addr;
	bus_pkg::data_t exp_victim_data;
	logic           fetch_seen;
	logic           evict_seen;

	unordered_cache #(.line_count(line_count), .age_width(age_width)) u_dut (
		.clk, .reset, .cpu_req, .cpu_rsp, .ready, .mem_req, .mem_rsp
	);

	backing_memory u_memory (.clk, .reset, .mem_req, .mem_rsp);

	always #4 clk = ~clk;

	// remembers which memory requests the current access went through
	always @(posedge clk) begin
		if (reset || cpu_req.valid) begin
			fetch_seen <= 1'b0;
			evict_seen <= 1'b0;
		end else begin
			fetch_seen <= fetch_seen || mem_req.fetch;
			evict_seen <= evict_seen || mem_req.evict;
		end
	end

	task automatic fail_run;
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	a_reset: assert property (@(posedge clk)
		$fell(reset) |-> ready && !cpu_rsp.valid && !mem_req.fetch && !mem_req.evict)
		else begin
			$display("Error: after reset ready %h cpu_rsp.valid %h fetch %h evict %h",
				$sampled(ready), $sampled(cpu_rsp.valid), $sampled(mem_req.fetch),
				$sampled(mem_req.evict));
			fail_run();
		end
	a_ready_low: assert property (@(posedge clk) disable iff (reset)
		cpu_req.valid |=> !ready)
		else begin
			$display("ready stayed high in the cycle after a request was accepted");
			fail_run();
		end
	a_ready_back: assert property (@(posedge clk) disable iff (reset)
		cpu_req.valid && exp_hit |=> ##1 ready)
		else begin
			$display("ready did not return two cycles after a hit was accepted");
			fail_run();
		end
	a_rsp_data: assert property (@(posedge clk) disable iff (reset)
		cpu_rsp.valid |-> cpu_rsp.data == exp_data)
		else begin
			$display("Error: cpu_rsp.data %h, expected %h", $sampled(cpu_rsp.data), exp_data);
			fail_run();
		end
	a_hit_latency: assert property (@(posedge clk) disable iff (reset)
		cpu_req.valid && exp_hit |=> cpu_rsp.valid && !mem_req.fetch && !mem_req.evict)
		else begin
			$display("a predicted hit did not answer in the next cycle without memory traffic");
			fail_run();
		end
	a_miss_wait: assert property (@(posedge clk) disable iff (reset)
		cpu_req.valid && !exp_hit |=> !cpu_rsp.valid)
		else begin
			$display("a predicted miss answered at once without going to memory");
			fail_run();
		end
	a_miss_path: assert property (@(posedge clk) disable iff (reset)
		cpu_rsp.valid && !exp_hit |-> fetch_seen && (evict_seen == exp_full))
		else begin
			$display("a miss finished without the expected fetch and write-back");
			fail_run();
		end
	a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
		mem_req.fetch |-> mem_req.addr == exp_addr)
		else begin
			$display("Error: mem_req.addr %h on fetch, expected %h", $sampled(mem_req.addr),
				exp_addr);
			fail_run();
		end
	a_evict_victim: assert property (@(posedge clk) disable iff (reset)
		mem_req.evict |-> exp_full && mem_req.addr == exp_victim_addr
			&& mem_req.data == exp_victim_data)
		else begin
			$display("Error: mem_req.addr %h mem_req.data %h on evict, expected %h %h",
				$sampled(mem_req.addr), $sampled(mem_req.data), exp_victim_addr,
				exp_victim_data);
			fail_run();
		end
	a_search_first: assert property (@(posedge clk) disable iff (reset)
		$rose(mem_req.evict) |-> $past(u_dut.u_miss_controller.state) == cache_pkg::ctrl_search)
		else begin
			$display("a write-back started without a victim search before it");
			fail_run();
		end

	// applies one access to the line model, the oldest lowest line is the victim
	task automatic predict(input bus_pkg::op_e op, input bus_pkg::addr_t addr,
		input bus_pkg::data_t data);
		int idx;
		int free_line;
		idx = -1;
		free_line = -1;
		for (int i = line_count - 1; i >= 0; i--) begin
			if (line_valid[i] && line_addr[i] == addr) idx = i;
			if (!line_valid[i]) free_line = i;
		end
		exp_hit = (idx >= 0);
		exp_full = 1'b0;
		exp_addr = addr;
		if (idx < 0) begin
			idx = free_line;
			if (free_line < 0) begin
				idx = 0;
				for (int i = 1; i < line_count; i++) begin
					if (line_age[i] > line_age[idx]) idx = i;
				end
				exp_full = 1'b1;
				exp_victim_addr = line_addr[idx];
				exp_victim_data = line_data[idx];
			end
			line_valid[idx] = 1'b1;
			line_addr[idx] = addr;
		end
		if (op == bus_pkg::op_write) ref_mem[addr] = data;
		line_data[idx] = ref_mem[addr];
		exp_data = ref_mem[addr];
		for (int i = 0; i < line_count; i++) begin
			if (i == idx) begin
				line_age[i] = '0;
			end else if (line_valid[i] && line_age[i] != '1) begin
				line_age[i] = line_age[i] + 1'b1;
			end
		end
	endtask

	// called on a falling edge, returns on the falling edge that shows the response
	task automatic do_access(input bus_pkg::op_e op, input bus_pkg::addr_t addr,
		input bus_pkg::data_t data);
		int waited;
		waited = 0;
		while (!ready && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!ready) begin
			$display("the cache did not become ready for a new request");
			fail_run();
		end else begin
			predict(op, addr, data);
			cpu_req.valid = 1'b1;
			cpu_req.op = op;
			cpu_req.addr = addr;
			cpu_req.data = data;
			@(negedge clk);
			cpu_req.valid = 1'b0;
			waited = 0;
			while (!cpu_rsp.valid && waited < wait_limit) begin
				@(negedge clk);
				waited++;
			end
			if (!cpu_rsp.valid) begin
				$display("no response arrived for the request to address %h", addr);
				fail_run();
			end
		end
	endtask

	initial begin
		bus_pkg::op_e op;
		reset = 1'b1;
		cpu_req = '0;
		exp_hit = 1'b0;
		exp_full = 1'b0;
		exp_addr = '0;
		exp_data = '0;
		exp_victim_addr = '0;
		exp_victim_data = '0;
		void'($urandom(32'h23cc_2662));
		for (int a = 0; a < 256; a++) ref_mem[a] = bus_pkg::data_t'(a) ^ 16'ha5a5;
		for (int i = 0; i < line_count; i++) begin
			line_valid[i] = 1'b0;
			line_age[i] = '0;
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		do_access(bus_pkg::op_read, 8'h03, '0); // empty cache, fetch only
		do_access(bus_pkg::op_write, 8'h03, 16'h1234);
		do_access(bus_pkg::op_read, 8'h03, '0);
		do_access(bus_pkg::op_read, 8'h05, '0);
		do_access(bus_pkg::op_read, 8'h07, '0);
		do_access(bus_pkg::op_read, 8'h09, '0);
		do_access(bus_pkg::op_read, 8'h0b, '0); // line of address 3 is oldest and dirty
		do_access(bus_pkg::op_read, 8'h03, '0);
		repeat (300) begin
			op = ($urandom_range(1, 0) == 1) ? bus_pkg::op_write : bus_pkg::op_read;
			do_access(op, bus_pkg::addr_t'($urandom_range(11, 0)),
				bus_pkg::data_t'($urandom()));
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// File: test/backing_memory.sv
`timescale 1ns/1ns

module backing_memory (
	input  logic              clk,
	input  logic              reset,
	input  bus_pkg::mem_req_t mem_req,
	output bus_pkg::mem_rsp_t mem_rsp
);

	bus_pkg::data_t words [256];
	logic           busy; // a fetch or write-back is being timed
	int unsigned    remaining;

	initial begin
		mem_rsp <= '0;
	end

	// answers on the falling edge, at the earliest one cycle after the request is seen
	always @(negedge clk) begin
		mem_rsp.fetch_valid <= 1'b0;
		mem_rsp.evict_ack <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
			remaining <= 0;
			for (int a = 0; a < 256; a++) begin
				words[a] <= bus_pkg::data_t'(a) ^ 16'ha5a5;
			end
		end else if (busy) begin
			if (remaining > 1) begin
				remaining <= remaining - 1;
			end else if (mem_req.evict) begin
				busy <= 1'b0;
				words[mem_req.addr] <= mem_req.data; // write-back lands before any refetch
				mem_rsp.evict_ack <= 1'b1;
			end else begin
				busy <= 1'b0;
				mem_rsp.fetch_valid <= 1'b1;
				mem_rsp.data <= words[mem_req.addr];
			end
		end else if (mem_req.fetch || mem_req.evict) begin
			busy <= 1'b1;
			remaining <= $urandom_range(6, 1);
		end
	end

endmodule

// File: source/unordered_cache.sv
`timescale 1ns/1ns

module unordered_cache #(
	parameter int line_count = 4,
	parameter int age_width  = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  bus_pkg::cpu_req_t cpu_req,
	output bus_pkg::cpu_rsp_t cpu_rsp,
	output logic              ready,
	output bus_pkg::mem_req_t mem_req,
	input  bus_pkg::mem_rsp_t mem_rsp
);

	localparam int index_width = $clog2(line_count);

	typedef logic [index_width-1:0] index_t;

	bus_pkg::addr_t        lookup_addr;
	logic                  hit;
	index_t                hit_index;
	bus_pkg::data_t        hit_data;
	logic                  miss;
	logic                  access;
	index_t                access_index;
	logic                  write_enable;
	bus_pkg::data_t        write_data;
	logic                  has_free;
	index_t                free_index;
	logic [line_count-1:0] valid_lines;
	index_t                scan_index;
	bus_pkg::addr_t        scan_addr;
	bus_pkg::data_t        scan_data;
	logic [age_width-1:0]  scan_age;
	logic                  scan_saturated;
	cache_pkg::line_load_t load_cmd;
	index_t                load_index;

	access_port #(.line_count(line_count)) u_access_port (
		.clk, .reset, .cpu_req, .hit, .hit_index, .hit_data,
		.cpu_rsp, .ready, .lookup_addr, .miss, .access, .access_index,
		.write_enable, .write_data
	);

	line_store #(.line_count(line_count)) u_line_store (
		.clk, .reset, .lookup_addr, .access, .access_index, .write_enable, .write_data,
		.load_cmd, .load_index, .scan_index,
		.hit, .hit_index, .hit_data, .has_free, .free_index, .valid_lines,
		.scan_addr, .scan_data
	);

	age_tracker #(.line_count(line_count), .age_width(age_width)) u_age_tracker (
		.clk, .reset, .access, .access_index, .valid_lines, .scan_index,
		.scan_age, .scan_saturated
	);

	miss_controller #(.line_count(line_count), .age_width(age_width)) u_miss_controller (
		.clk, .reset, .miss, .lookup_addr, .has_free, .free_index,
		.scan_age, .scan_saturated, .scan_addr, .scan_data, .mem_rsp,
		.mem_req, .scan_index, .load_cmd, .load_index
	);

endmodule

// File: source/miss_controller.sv
`timescale 1ns/1ns

module miss_controller #(
	parameter int line_count = 4,
	parameter int age_width  = 4
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          miss,
	input  bus_pkg::addr_t                lookup_addr,
	input  logic                          has_free,
	input  logic [$clog2(line_count)-1:0] free_index,
	input  logic [age_width-1:0]          scan_age,
	input  logic                          scan_saturated,
	input  bus_pkg::addr_t                scan_addr,
	input  bus_pkg::data_t                scan_data,
	input  bus_pkg::mem_rsp_t             mem_rsp,
	output bus_pkg::mem_req_t             mem_req,
	output logic [$clog2(line_count)-1:0] scan_index,
	output cache_pkg::line_load_t         load_cmd,
	output logic [$clog2(line_count)-1:0] load_index
);

	localparam int index_width = $clog2(line_count);

	typedef logic [index_width-1:0] index_t;
	typedef logic [age_width-1:0]   age_t;

	cache_pkg::ctrl_state_e state;
	index_t                 scan_q;
	logic                   from_free; // the fill goes to a free line, not to the victim
	index_t                 best_index;
	age_t                   best_age;
	bus_pkg::addr_t         best_addr;
	bus_pkg::data_t         best_data;
	logic                   last_line;
	logic                   take_best;

	assign last_line = (scan_q == index_t'(line_count - 1));

	// line 0 always seeds the victim, later lines need a strictly greater age
	assign take_best = (state == cache_pkg::ctrl_search) && (scan_q == '0 || scan_age > best_age);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_pkg::ctrl_idle;
			scan_q <= '0;
			from_free <= 1'b0;
		end else begin
			case (state)
				cache_pkg::ctrl_idle: begin
					if (miss) begin
						from_free <= has_free;
						scan_q <= '0;
						state <= has_free ? cache_pkg::ctrl_fetch : cache_pkg::ctrl_search;
					end
				end
				cache_pkg::ctrl_search: begin
					// nothing can be older than a saturated line, stop early
					if (scan_saturated || last_line) begin
						state <= cache_pkg::ctrl_evict;
					end else begin
						scan_q <= scan_q + 1'b1;
					end
				end
				cache_pkg::ctrl_evict: begin
					if (mem_rsp.evict_ack) begin
						state <= cache_pkg::ctrl_fetch;
					end
				end
				cache_pkg::ctrl_fetch: begin
					if (mem_rsp.fetch_valid) begin
						state <= cache_pkg::ctrl_idle; // the pending request hits next cycle
					end
				end
				default: state <= cache_pkg::ctrl_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_best) begin
			best_index <= scan_q;
			best_age <= scan_age;
			best_addr <= scan_addr;
			best_data <= scan_data;
		end
	end

	assign scan_index = scan_q;

	always_comb begin
		mem_req.fetch = (state == cache_pkg::ctrl_fetch);
		mem_req.evict = (state == cache_pkg::ctrl_evict);
		mem_req.addr = mem_req.evict ? best_addr : lookup_addr;
		mem_req.data = best_data;
	end

	always_comb begin
		load_cmd.load = (state == cache_pkg::ctrl_fetch) && mem_rsp.fetch_valid;
		load_cmd.addr = lookup_addr;
		load_cmd.data = mem_rsp.data;
	end

	assign load_index = from_free ? free_index : best_index;

	assert property (@(posedge clk) disable iff (reset) !(mem_req.fetch && mem_req.evict))
		else $error("fetch and evict requested together");

	// a free-line fill must still find the line free, a victim fill only happens on a full cache
	assert property (@(posedge clk) disable iff (reset)
		load_cmd.load |-> (from_free ? has_free : !has_free))
		else $error("line load does not target a free line or the evicted victim");

endmodule

// File: source/access_port.sv
`timescale 1ns/1ns

module access_port #(
	parameter int line_count = 4
) (
	input  logic                          clk,
	input  logic                          reset,
	input  bus_pkg::cpu_req_t             cpu_req,
	input  logic                          hit,
	input  logic [$clog2(line_count)-1:0] hit_index,
	input  bus_pkg::data_t                hit_data,
	output bus_pkg::cpu_rsp_t             cpu_rsp,
	output logic                          ready,
	output bus_pkg::addr_t                lookup_addr,
	output logic                          miss,
	output logic                          access,
	output logic [$clog2(line_count)-1:0] access_index,
	output logic                          write_enable,
	output bus_pkg::data_t                write_data
);

	bus_pkg::cpu_req_t req_q; // valid doubles as the pending flag
	logic              is_write;

	// only the valid bit is control state, the rest is payload
	always_ff @(posedge clk) begin
		if (reset) begin
			req_q.valid <= 1'b0;
		end else if (cpu_req.valid && ready) begin
			req_q <= cpu_req;
		end else if (access) begin
			req_q.valid <= 1'b0; // retired by its hit
		end
	end

	assign is_write = (req_q.op == bus_pkg::op_write);

	assign ready = !req_q.valid;
	assign lookup_addr = req_q.addr;
	assign access = req_q.valid && hit;
	assign miss = req_q.valid && !hit; // held until the fill makes it hit
	assign access_index = hit_index;
	assign write_enable = is_write;
	assign write_data = req_q.data;

	// a write answers with the word it stored
	always_comb begin
		cpu_rsp.valid = access;
		cpu_rsp.data = is_write ? req_q.data : hit_data;
	end

	// the client may only strobe while the cache is free, nothing is buffered beyond one request
	assert property (@(posedge clk) disable iff (reset) cpu_req.valid |-> ready)
		else $error("client request arrived while the cache was busy");

endmodule

// File: source/age_tracker.sv
`timescale 1ns/1ns

module age_tracker #(
	parameter int line_count = 4,
	parameter int age_width  = 4
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          access,
	input  logic [$clog2(line_count)-1:0] access_index,
	input  logic [line_count-1:0]         valid_lines,
	input  logic [$clog2(line_count)-1:0] scan_index,
	output logic [age_width-1:0]          scan_age,
	output logic                          scan_saturated
);

	localparam int index_width = $clog2(line_count);

	typedef logic [index_width-1:0] index_t;
	typedef logic [age_width-1:0]   age_t;

	age_t age_q [line_count];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < line_count; i++) begin
				age_q[i] <= '0;
			end
		end else if (access) begin
			for (int i = 0; i < line_count; i++) begin
				if (index_t'(i) == access_index) begin
					age_q[i] <= '0; // the line just used is the youngest
				end else if (valid_lines[i] && !(&age_q[i])) begin
					age_q[i] <= age_q[i] + 1'b1; // saturates at all ones
				end
			end
		end
	end

	assign scan_age = age_q[scan_index];

	// a saturated line cannot be beaten, so the scan may stop there
	assign scan_saturated = &scan_age;

endmodule

// File: source/line_store.sv
`timescale 1ns/1ns

module line_store #(
	parameter int line_count = 4
) (
	input  logic                          clk,
	input  logic                          reset,
	input  bus_pkg::addr_t                lookup_addr,
	input  logic                          access,
	input  logic [$clog2(line_count)-1:0] access_index,
	input  logic                          write_enable,
	input  bus_pkg::data_t                write_data,
	input  cache_pkg::line_load_t         load_cmd,
	input  logic [$clog2(line_count)-1:0] load_index,
	input  logic [$clog2(line_count)-1:0] scan_index,
	output logic                          hit,
	output logic [$clog2(line_count)-1:0] hit_index,
	output bus_pkg::data_t                hit_data,
	output logic                          has_free,
	output logic [$clog2(line_count)-1:0] free_index,
	output logic [line_count-1:0]         valid_lines,
	output bus_pkg::addr_t                scan_addr,
	output bus_pkg::data_t                scan_data
);

	localparam int index_width = $clog2(line_count);

	typedef logic [index_width-1:0] index_t;

	logic [line_count-1:0] valid_q;
	bus_pkg::addr_t        addr_q [line_count];
	bus_pkg::data_t        data_q [line_count];
	logic [line_count-1:0] match;

	// every line compares against the pending address at once
	always_comb begin
		for (int i = 0; i < line_count; i++) begin
			match[i] = valid_q[i] && (addr_q[i] == lookup_addr);
		end
	end

	// walk downwards so that the lowest matching or empty line is the one left standing
	always_comb begin
		hit_index = '0;
		free_index = '0;
		for (int i = line_count - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_index = index_t'(i);
			end
			if (!valid_q[i]) begin
				free_index = index_t'(i);
			end
		end
	end

	assign hit = |match;
	assign hit_data = data_q[hit_index];
	assign has_free = ~&valid_q;
	assign valid_lines = valid_q;
	assign scan_addr = addr_q[scan_index]; // victim candidate for the controller
	assign scan_data = data_q[scan_index];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
		end else if (load_cmd.load) begin
			valid_q[load_index] <= 1'b1;
		end
	end

	// a fill and a client write never meet, the client is stalled during a miss
	always_ff @(posedge clk) begin
		if (load_cmd.load) begin
			addr_q[load_index] <= load_cmd.addr;
			data_q[load_index] <= load_cmd.data;
		end else if (access && write_enable) begin
			data_q[access_index] <= write_data;
		end
	end

	// a fill only ever brings in an address that missed, so duplicates cannot form
	assert property (@(posedge clk) disable iff (reset) $onehot0(match))
		else $error("more than one cache line holds address %h", lookup_addr);

endmodule

// File: source/cache_pkg.sv
package cache_pkg;

	// miss handling states of the controller
	typedef enum logic [1:0] {
		ctrl_idle   = 2'd0,
		ctrl_search = 2'd1, // scanning ages for the oldest line
		ctrl_evict  = 2'd2, // waiting for the write-back to be taken
		ctrl_fetch  = 2'd3  // waiting for the fill word
	} ctrl_state_e;

	// the target line index travels beside this command, its width follows line_count
	typedef struct packed {
		logic           load;
		bus_pkg::addr_t addr;
		bus_pkg::data_t data;
	} line_load_t;

endpackage

// File: source/bus_pkg.sv
package bus_pkg;

	localparam int addr_width = 8;
	localparam int data_width = 16;

	typedef logic [addr_width-1:0] addr_t;
	typedef logic [data_width-1:0] data_t;

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} op_e;

	// one client access, valid for a single cycle
	typedef struct packed {
		logic  valid;
		op_e   op;
		addr_t addr;
		data_t data;
	} cpu_req_t;

	typedef struct packed {
		logic  valid;
		data_t data;
	} cpu_rsp_t;

	// fetch and evict are levels held until memory answers
	typedef struct packed {
		logic  fetch;
		logic  evict;
		addr_t addr;
		data_t data; // write-back data, only meaningful with evict
	} mem_req_t;

	typedef struct packed {
		logic  fetch_valid; // one-cycle strobe carrying the fill word
		logic  evict_ack;
		data_t data;
	} mem_rsp_t;

endpackage
